//--- verilog.f
hdl/armPkg.sv
hdl/hazardIf.sv
hdl/alu.sv
hdl/regFile.sv
hdl/condUnit.sv
hdl/controller.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/armCore.sv
tb/armCoreTb.sv

//--- tb/armCoreTb.sv
/*
 * Testbench for the ARM core
 * Hand-encoded programs run against combinational instruction and data
 * memory models; stores are logged and compared with expected values
 */
`timescale 1ns/10ps
`default_nettype none

module armCoreTb
   import armPkg::*;
();
   localparam int TIMEOUT_CYCLES = 500;
   localparam int IMEM_WORDS     = 128;
   localparam int DMEM_WORDS     = 256;
   localparam logic [3:0] OP_AND = 4'b0000;   // ARM data processing opcodes
   localparam logic [3:0] OP_SUB = 4'b0010;
   localparam logic [3:0] OP_ADD = 4'b0100;
   localparam logic [3:0] OP_ORR = 4'b1100;

   logic  clk;
   logic  reset;
   word_t imemAddr;
   word_t imemData;
   word_t dmemAddr;
   word_t dmemWriteData;
   logic  dmemWrite;
   word_t dmemReadData;

   word_t imem [0:IMEM_WORDS-1];
   word_t dmem [0:DMEM_WORDS-1];
   word_t storeAddr [$];
   word_t storeData [$];
   word_t expAddr [$];
   word_t expData [$];
   int    pcIdx;
   int    seed;

   armCore armCore_inst (
      .clk           (clk),
      .reset         (reset),
      .imemAddr      (imemAddr),
      .imemData      (imemData),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemWrite     (dmemWrite),
      .dmemReadData  (dmemReadData)
   );

   assign imemData     = imem[imemAddr[8:2]];
   assign dmemReadData = dmem[dmemAddr[9:2]];

   // Store completes on the edge that ends its cycle
   always @(posedge clk)
   begin
      if (dmemWrite)
      begin
         dmem[dmemAddr[9:2]] <= dmemWriteData;
         storeAddr.push_back(dmemAddr);
         storeData.push_back(dmemWriteData);
      end
   end

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic word_t dmemFill(input int idx);
      return 32'hA500_0000 ^ (word_t'(idx) * 32'h0101_0107);
   endfunction

   function automatic word_t dpImm(input cond_t c, input logic [3:0] op, input logic s,
                                   input regAddr_t rn, input regAddr_t rd,
                                   input logic [7:0] imm);
      return {c, 2'b00, 1'b1, op, s, rn, rd, 4'h0, imm};
   endfunction

   function automatic word_t dpReg(input cond_t c, input logic [3:0] op, input logic s,
                                   input regAddr_t rn, input regAddr_t rd,
                                   input regAddr_t rm);
      return {c, 2'b00, 1'b0, op, s, rn, rd, 8'h00, rm};
   endfunction

   // Pre-indexed, offset added, word access
   function automatic word_t memOp(input cond_t c, input logic load, input regAddr_t rn,
                                   input regAddr_t rd, input logic [11:0] off);
      return {c, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
   endfunction

   function automatic word_t branchTo(input cond_t c, input int from, input int to);
      int off;
      off = to - from - 2;   // Target is PC+8 plus the word offset
      return {c, 4'b1010, off[23:0]};
   endfunction

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkEq(input string name, input word_t actual, input word_t expected);
      if (actual !== expected)
         abortRun($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
   endtask

   task automatic emit(input word_t instr);
      imem[pcIdx] = instr;
      pcIdx++;
   endtask

   task automatic expectStore(input word_t addr, input word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   // Core held in reset while the memories are rewritten
   task automatic beginProgram();
      int i;
      reset = 1'b1;
      for (i = 0; i < IMEM_WORDS; i++)
         imem[i] = {4'hF, 28'(i * INSTR_BYTES)};   // Never-condition filler
      for (i = 0; i < DMEM_WORDS; i++)
         dmem[i] <= dmemFill(i);
      storeAddr.delete();
      storeData.delete();
      expAddr.delete();
      expData.delete();
      pcIdx = 0;
   endtask

   task automatic holdReset();
      repeat (10)
      begin
         @(negedge clk);
         checkEq("dmemWrite", word_t'(dmemWrite), '0);
         checkEq("imemAddr", imemAddr, '0);
      end
      reset = 1'b0;
   endtask

   // Clear, then shift in one byte at a time by doubling
   task automatic buildWord(input regAddr_t rd, input word_t value);
      int b;
      emit(dpImm(AL, OP_AND, 1'b0, rd, rd, 8'h00));
      emit(dpImm(AL, OP_ADD, 1'b0, rd, rd, value[31:24]));
      for (b = 2; b >= 0; b--)
      begin
         repeat (8) emit(dpReg(AL, OP_ADD, 1'b0, rd, rd, rd));
         emit(dpImm(AL, OP_ORR, 1'b0, rd, rd, value[b*8 +: 8]));
      end
   endtask

   task automatic runProgram();
      int cycles;
      int i;
      emit(branchTo(AL, pcIdx, pcIdx));   // Park on a branch to itself
      holdReset();
      cycles = 0;
      while (storeAddr.size() < expAddr.size() && cycles < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         cycles++;
      end
      if (storeAddr.size() < expAddr.size())
         abortRun($sformatf("Timed out after %0d cycles with %0d of %0d stores seen",
                            cycles, storeAddr.size(), expAddr.size()));
      for (i = 0; i < expAddr.size(); i++)
      begin
         checkEq($sformatf("dmemAddr of store %0d", i), storeAddr[i], expAddr[i]);
         checkEq($sformatf("dmemWriteData of store %0d", i), storeData[i], expData[i]);
      end
   endtask

   task automatic resetAndFetch();
      int k;
      $display("Reset and fetch sequence");
      beginProgram();
      holdReset();
      for (k = 1; k <= 6; k++)
      begin
         @(negedge clk);
         checkEq("imemAddr", imemAddr, word_t'(k * INSTR_BYTES));
      end
   endtask

   task automatic dataProcForwarding();
      word_t a;
      word_t b;
      word_t sum;
      word_t diff;
      word_t andRes;
      word_t orRes;
      $display("Data processing with forwarding");
      a      = $random(seed);
      b      = $random(seed);
      sum    = a + b;
      diff   = b - sum;
      andRes = diff & a;
      orRes  = andRes | sum;
      beginProgram();
      emit(dpImm(AL, OP_AND, 1'b0, 4'd7, 4'd7, 8'h00));   // Base address
      buildWord(4'd1, a);
      buildWord(4'd2, b);
      emit(dpReg(AL, OP_ADD, 1'b0, 4'd1, 4'd3, 4'd2));
      emit(dpReg(AL, OP_SUB, 1'b0, 4'd2, 4'd4, 4'd3));    // r2 from writeback
      emit(dpReg(AL, OP_AND, 1'b0, 4'd4, 4'd5, 4'd1));
      emit(dpReg(AL, OP_ORR, 1'b0, 4'd5, 4'd6, 4'd3));
      emit(memOp(AL, 1'b0, 4'd7, 4'd6, 12'h040));          // Store data forwarded
      emit(memOp(AL, 1'b0, 4'd7, 4'd5, 12'h044));
      emit(memOp(AL, 1'b0, 4'd7, 4'd4, 12'h048));
      emit(memOp(AL, 1'b0, 4'd7, 4'd3, 12'h04C));
      expectStore(32'h40, orRes);
      expectStore(32'h44, andRes);
      expectStore(32'h48, diff);
      expectStore(32'h4C, sum);
      runProgram();
   endtask

   task automatic loadUseStall();
      word_t       w;
      logic [7:0]  imm;
      logic [11:0] ldOff;
      logic [11:0] sumOff;
      $display("Load-use stall");
      w      = $random(seed);
      imm    = $random(seed);
      ldOff  = {3'b000, 7'($random(seed)), 2'b00};
      sumOff = {3'b010, 7'($random(seed)), 2'b00};
      beginProgram();
      emit(dpImm(AL, OP_AND, 1'b0, 4'd1, 4'd1, 8'h00));
      buildWord(4'd2, w);
      emit(memOp(AL, 1'b0, 4'd1, 4'd2, ldOff));
      emit(memOp(AL, 1'b1, 4'd1, 4'd3, ldOff));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd3, 4'd4, imm));      // Uses the load at once
      emit(memOp(AL, 1'b0, 4'd1, 4'd4, sumOff));
      expectStore(word_t'(ldOff), w);
      expectStore(word_t'(sumOff), w + imm);
      runProgram();
   endtask

   task automatic flagsAndConditions();
      word_t x;
      word_t s;
      word_t l;
      logic  lt;
      logic  cs;
      word_t condSum;
      $display("Flags and condition codes");
      x  = $random(seed) & 32'hFF;
      s  = $random(seed) & 32'h7F;
      l  = s + 1 + ($random(seed) & 32'h7F);
      lt = $signed(s) < $signed(l);
      cs = s >= l;                              // No borrow
      condSum = (lt ? 1 : 2) + (cs ? 8 : 4);
      beginProgram();
      emit(dpImm(AL, OP_AND, 1'b0, 4'd1, 4'd1, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd2, 4'd2, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd3, 4'd3, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd5, 4'd5, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd6, 4'd6, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd12, 4'd12, 8'h00));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd2, 4'd2, x[7:0]));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd3, 4'd3, x[7:0]));
      emit(dpReg(AL, OP_SUB, 1'b1, 4'd2, 4'd4, 4'd3));     // SUBS of equal operands
      emit(dpImm(EQ, OP_ADD, 1'b0, 4'd5, 4'd5, 8'd1));
      emit(dpImm(NE, OP_ADD, 1'b0, 4'd6, 4'd6, 8'd1));
      emit(memOp(AL, 1'b0, 4'd1, 4'd5, 12'h080));
      emit(memOp(AL, 1'b0, 4'd1, 4'd6, 12'h084));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd7, 4'd7, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd8, 4'd8, 8'h00));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd7, 4'd7, s[7:0]));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd8, 4'd8, l[7:0]));
      emit(dpReg(AL, OP_SUB, 1'b1, 4'd7, 4'd9, 4'd8));     // Smaller minus larger
      emit(dpReg(AL, OP_SUB, 1'b0, 4'd8, 4'd11, 4'd7));    // Flags kept without S
      emit(dpImm(LT, OP_ADD, 1'b0, 4'd12, 4'd12, 8'd1));
      emit(dpImm(GE, OP_ADD, 1'b0, 4'd12, 4'd12, 8'd2));
      emit(dpImm(CC, OP_ADD, 1'b0, 4'd12, 4'd12, 8'd4));
      emit(dpImm(CS, OP_ADD, 1'b0, 4'd12, 4'd12, 8'd8));
      emit(memOp(AL, 1'b0, 4'd1, 4'd12, 12'h088));
      emit(memOp(AL, 1'b0, 4'd1, 4'd11, 12'h08C));
      emit(memOp(AL, 1'b0, 4'd1, 4'd9, 12'h090));
      expectStore(32'h80, (x - x == 0) ? 32'd1 : 32'd0);
      expectStore(32'h84, (x - x != 0) ? 32'd1 : 32'd0);
      expectStore(32'h88, condSum);
      expectStore(32'h8C, l - s);
      expectStore(32'h90, s - l);
      runProgram();
   endtask

   task automatic takenAndFailedBranches();
      word_t m;
      word_t k;
      int    markerIdx;
      $display("Taken and failed branches");
      m = $random(seed) & 32'hFF;
      k = $random(seed) & 32'hFF;
      markerIdx = 32'hC0 / INSTR_BYTES;
      beginProgram();
      emit(dpImm(AL, OP_AND, 1'b0, 4'd1, 4'd1, 8'h00));
      emit(dpImm(AL, OP_AND, 1'b0, 4'd2, 4'd2, 8'h00));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd2, 4'd2, m[7:0]));
      emit(branchTo(AL, pcIdx, pcIdx + 3));
      emit(memOp(AL, 1'b0, 4'd1, 4'd2, 12'h0C0));          // Skipped markers
      emit(memOp(AL, 1'b0, 4'd1, 4'd2, 12'h0C0));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd2, 4'd3, k[7:0]));   // Branch target
      emit(dpReg(AL, OP_SUB, 1'b1, 4'd2, 4'd4, 4'd2));     // Sets Z
      emit(branchTo(NE, pcIdx, pcIdx + 3));
      emit(memOp(AL, 1'b0, 4'd1, 4'd3, 12'h0C4));
      emit(dpImm(AL, OP_ADD, 1'b0, 4'd3, 4'd3, 8'd1));
      emit(memOp(AL, 1'b0, 4'd1, 4'd3, 12'h0C8));
      expectStore(32'hC4, m + k);
      expectStore(32'hC8, m + k + 1);
      runProgram();
      checkEq("dmem marker word", dmem[markerIdx], dmemFill(markerIdx));
   endtask

   initial
   begin
      seed  = 32'h51d6;
      reset = 1'b1;
      beginProgram();
      resetAndFetch();
      dataProcForwarding();
      loadUseStall();
      flagsAndConditions();
      takenAndFailedBranches();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/armCore.sv
/*
 * ARM core top level
 * Five-stage pipeline for a subset of ARMv4 with separate instruction
 * and data memory ports answering in the same cycle
 */
`timescale 1ns/10ps
`default_nettype none

module armCore import armPkg::*;
(
   input  logic  clk,
   input  logic  reset,
   output word_t imemAddr,
   input  word_t imemData,
   output word_t dmemAddr,
   output word_t dmemWriteData,
   output logic  dmemWrite,
   input  word_t dmemReadData
);
   word_t      instrD;
   flags_t     aluFlagsE;
   logic [1:0] regSrcD;
   immSrc_t    immSrcD;
   logic       aluSrcE;
   aluOp_t     aluControlE;
   logic       memToRegW;

   hazardIf hz (.clk(clk), .reset(reset));

   controller controller_inst (
      .clk         (clk),
      .reset       (reset),
      .instrD      (instrD),
      .aluFlagsE   (aluFlagsE),
      .regSrcD     (regSrcD),
      .immSrcD     (immSrcD),
      .aluSrcE     (aluSrcE),
      .aluControlE (aluControlE),
      .memToRegW   (memToRegW),
      .dmemWrite   (dmemWrite),
      .hz          (hz.control)
   );

   datapath datapath_inst (
      .clk           (clk),
      .reset         (reset),
      .imemAddr      (imemAddr),
      .imemData      (imemData),
      .instrD        (instrD),
      .regSrcD       (regSrcD),
      .immSrcD       (immSrcD),
      .aluSrcE       (aluSrcE),
      .aluControlE   (aluControlE),
      .memToRegW     (memToRegW),
      .aluFlagsE     (aluFlagsE),
      .dmemAddr      (dmemAddr),
      .dmemWriteData (dmemWriteData),
      .dmemReadData  (dmemReadData),
      .hz            (hz.datapath)
   );

   hazardUnit hazardUnit_inst (
      .hz (hz.hazard)
   );

endmodule

`default_nettype wire

//--- hdl/datapath.sv
/*
 * Pipeline datapath
 * PC and fetch, register read and immediate extension, forwarded
 * operands into the ALU, memory access and writeback selection
 */
`timescale 1ns/10ps
`default_nettype none

module datapath import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   output word_t      imemAddr,
   input  word_t      imemData,
   output word_t      instrD,
   input  logic [1:0] regSrcD,
   input  immSrc_t    immSrcD,
   input  logic       aluSrcE,
   input  aluOp_t     aluControlE,
   input  logic       memToRegW,
   output flags_t     aluFlagsE,
   output word_t      dmemAddr,
   output word_t      dmemWriteData,
   input  word_t      dmemReadData,
   hazardIf.datapath  hz
);
   word_t pcF;
   word_t pcPlus4F;
   word_t rd1D;
   word_t rd2D;
   word_t extImmD;
   word_t rd1E;
   word_t rd2E;
   word_t extImmE;
   word_t srcAE;
   word_t srcBE;
   word_t writeDataE;
   word_t aluResultE;
   word_t aluOutM;
   word_t writeDataM;
   word_t aluOutW;
   word_t readDataW;
   word_t resultW;

   function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
                                    input word_t memVal, input word_t wbVal);
      case (sel)
         FWD_MEMORY:    return memVal;
         FWD_WRITEBACK: return wbVal;
         default:       return regVal;
      endcase
   endfunction

   assign pcPlus4F = pcF + INSTR_BYTES;
   assign imemAddr = pcF;

   // Taken branch target comes straight from the ALU
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pcF <= '0;
      else if (!hz.stallF)
         pcF <= hz.branchTakenE ? aluResultE : pcPlus4F;
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         instrD <= '0;
      else if (hz.flushD)
         instrD <= '0;
      else if (!hz.stallD)
         instrD <= imemData;
   end

   assign hz.ra1D = regSrcD[0] ? regAddr_t'(PC_REG) : instrD[19:16];
   assign hz.ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

   regFile regFile_inst (
      .clk (clk),
      .we3 (hz.regWriteW),
      .ra1 (hz.ra1D),
      .ra2 (hz.ra2D),
      .wa3 (hz.wa3W),
      .wd3 (resultW),
      .r15 (pcPlus4F),   // Already PC+8 of the decode instruction
      .rd1 (rd1D),
      .rd2 (rd2D)
   );

   always_comb
   begin
      case (immSrcD)
         IMM8:     extImmD = {24'b0, instrD[7:0]};
         IMM12:    extImmD = {20'b0, instrD[11:0]};
         BRANCH24: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};   // Word offset
         default:  extImmD = '0;
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         {rd1E, rd2E, extImmE} <= '0;
         {hz.ra1E, hz.ra2E, hz.wa3E} <= '0;
      end
      else
      begin
         {rd1E, rd2E, extImmE} <= {rd1D, rd2D, extImmD};
         {hz.ra1E, hz.ra2E, hz.wa3E} <= {hz.ra1D, hz.ra2D, instrD[15:12]};
      end
   end

   assign srcAE      = fwdMux(hz.forwardAE, rd1E, aluOutM, resultW);
   assign writeDataE = fwdMux(hz.forwardBE, rd2E, aluOutM, resultW);
   assign srcBE      = aluSrcE ? extImmE : writeDataE;

   alu alu_inst (
      .a          (srcAE),
      .b          (srcBE),
      .aluControl (aluControlE),
      .result     (aluResultE),
      .flags      (aluFlagsE)
   );

   // Memory and writeback registers
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         {aluOutM, writeDataM, hz.wa3M} <= '0;
         {aluOutW, readDataW, hz.wa3W} <= '0;
      end
      else
      begin
         {aluOutM, writeDataM, hz.wa3M} <= {aluResultE, writeDataE, hz.wa3E};
         {aluOutW, readDataW, hz.wa3W} <= {aluOutM, dmemReadData, hz.wa3M};
      end
   end

   assign dmemAddr      = aluOutM;
   assign dmemWriteData = writeDataM;
   assign resultW       = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
/*
 * Hazard unit
 * Forwarding selects for both execute operands, the load-use stall
 * and the flushes on a taken branch
 */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import armPkg::*;
(
   hazardIf.hazard hz
);
   logic ldrStall;

   // Memory stage result is newer, so it wins
   function automatic fwdSel_t fwdSelect(input regAddr_t raE);
      if (hz.regWriteM && (raE == hz.wa3M))
         return FWD_MEMORY;
      else if (hz.regWriteW && (raE == hz.wa3W))
         return FWD_WRITEBACK;
      else
         return FWD_NONE;
   endfunction

   always_comb
   begin
      hz.forwardAE = fwdSelect(hz.ra1E);
      hz.forwardBE = fwdSelect(hz.ra2E);
   end

   assign ldrStall  = hz.memToRegE && ((hz.wa3E == hz.ra1D) || (hz.wa3E == hz.ra2D));
   assign hz.stallF = ldrStall;
   assign hz.stallD = ldrStall;
   assign hz.flushE = ldrStall | hz.branchTakenE;   // Bubble into execute
   assign hz.flushD = hz.branchTakenE;

   // A load and a branch never share the execute stage
   noStallOnBranch: assert property (@(posedge hz.clk) disable iff (hz.reset)
      !(hz.stallD && hz.branchTakenE));

endmodule

`default_nettype wire

//--- hdl/controller.sv
/*
 * Pipeline controller
 * Decodes the instruction in decode and carries its control bits through
 * execute, memory and writeback, gated by the condition check
 */
`timescale 1ns/10ps
`default_nettype none

module controller import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  word_t      instrD,
   input  flags_t     aluFlagsE,
   output logic [1:0] regSrcD,     // [0] R15 as first source, [1] Rd as second source
   output immSrc_t    immSrcD,
   output logic       aluSrcE,
   output aluOp_t     aluControlE,
   output logic       memToRegW,
   output logic       dmemWrite,
   hazardIf.control   hz
);
   typedef struct packed {
      cond_t      cond;
      logic [1:0] flagWrite;
      logic       branch;
      logic       memWrite;
      logic       regWrite;
      logic       memToReg;
      logic       aluSrc;
      aluOp_t     aluControl;
   } execCtrl_t;

   execCtrl_t ctrlD;
   execCtrl_t ctrlE;
   logic      condEx;
   logic      memToRegM;

   always_comb
   begin
      ctrlD      = '0;
      ctrlD.cond = cond_t'(instrD[31:28]);
      regSrcD    = 2'b00;
      immSrcD    = IMM8;
      case (opClass_t'(instrD[27:26]))
         DATA_PROC:
         begin
            ctrlD.aluSrc   = instrD[25];          // Immediate form
            ctrlD.regWrite = 1'b1;
            case (instrD[24:21])
               4'b0010: ctrlD.aluControl = ALU_SUB;
               4'b0000: ctrlD.aluControl = ALU_AND;
               4'b1100: ctrlD.aluControl = ALU_ORR;
               default: ctrlD.aluControl = ALU_ADD;
            endcase
            // C and V only from arithmetic ops
            ctrlD.flagWrite[1] = instrD[20];
            ctrlD.flagWrite[0] = instrD[20] &
                                 (ctrlD.aluControl == ALU_ADD || ctrlD.aluControl == ALU_SUB);
         end
         MEMORY:
         begin
            immSrcD      = IMM12;
            ctrlD.aluSrc = 1'b1;
            if (instrD[20])
            begin
               ctrlD.memToReg = 1'b1;             // LDR
               ctrlD.regWrite = 1'b1;
            end
            else
            begin
               regSrcD        = 2'b10;            // STR reads Rd
               ctrlD.memWrite = 1'b1;
            end
         end
         BRANCH:
         begin
            regSrcD      = 2'b01;
            immSrcD      = BRANCH24;
            ctrlD.aluSrc = 1'b1;
            ctrlD.branch = 1'b1;
         end
         default:
            ctrlD.aluControl = ALU_ADD;
      endcase
   end

   // Execute register takes a bubble on a load stall or taken branch
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrlE <= '0;
      else if (hz.flushE)
         ctrlE <= '0;
      else
         ctrlE <= ctrlD;
   end

   condUnit condUnit_inst (
      .clk        (clk),
      .reset      (reset),
      .condE      (ctrlE.cond),
      .aluFlagsE  (aluFlagsE),
      .flagWriteE (ctrlE.flagWrite),
      .condEx     (condEx)
   );

   assign aluSrcE         = ctrlE.aluSrc;
   assign aluControlE     = ctrlE.aluControl;
   assign hz.memToRegE    = ctrlE.memToReg;
   assign hz.branchTakenE = ctrlE.branch & condEx;

   // Failed conditions drop their writes on the way into memory
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         {dmemWrite, memToRegM, hz.regWriteM} <= '0;
         {memToRegW, hz.regWriteW} <= '0;
      end
      else
      begin
         dmemWrite    <= ctrlE.memWrite & condEx;
         memToRegM    <= ctrlE.memToReg;
         hz.regWriteM <= ctrlE.regWrite & condEx;
         memToRegW    <= memToRegM;
         hz.regWriteW <= hz.regWriteM;
      end
   end

   // A store never writes a register
   storeNoRegWrite: assert property (@(posedge clk) disable iff (reset)
      !(dmemWrite && hz.regWriteM));

endmodule

`default_nettype wire

//--- hdl/condUnit.sv
/*
 * Condition unit
 * Holds the NZCV flags and evaluates the condition field of the
 * instruction in execute
 */
`timescale 1ns/10ps
`default_nettype none

module condUnit import armPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  cond_t      condE,
   input  flags_t     aluFlagsE,
   input  logic [1:0] flagWriteE,   // [1] N and Z, [0] C and V
   output logic       condEx
);
   flags_t flags;
   logic   ge;

   assign ge = (flags.n == flags.v);

   always_comb
   begin
      case (condE)
         EQ:      condEx = flags.z;
         NE:      condEx = ~flags.z;
         CS:      condEx = flags.c;
         CC:      condEx = ~flags.c;
         MI:      condEx = flags.n;
         PL:      condEx = ~flags.n;
         VS:      condEx = flags.v;
         VC:      condEx = ~flags.v;
         HI:      condEx = flags.c & ~flags.z;
         LS:      condEx = ~flags.c | flags.z;
         GE:      condEx = ge;
         LT:      condEx = ~ge;
         GT:      condEx = ~flags.z & ge;
         LE:      condEx = flags.z | ~ge;
         AL:      condEx = 1'b1;
         default: condEx = 1'b0;    // Never
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else if (condEx)
      begin
         if (flagWriteE[1])
         begin
            flags.n <= aluFlagsE.n;
            flags.z <= aluFlagsE.z;
         end
         if (flagWriteE[0])
         begin
            flags.c <= aluFlagsE.c;
            flags.v <= aluFlagsE.v;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
/*
 * Register file
 * R0 to R14, two combinational reads and a write on the falling edge
 * R15 reads return the PC+8 value from fetch
 */
`timescale 1ns/10ps
`default_nettype none

module regFile import armPkg::*;
(
   input  logic     clk,
   input  logic     we3,
   input  regAddr_t ra1,
   input  regAddr_t ra2,
   input  regAddr_t wa3,
   input  word_t    wd3,
   input  word_t    r15,
   output word_t    rd1,
   output word_t    rd2
);
   word_t regs [0:PC_REG-1];

   // Midcycle write so decode sees the writeback value
   always_ff @(negedge clk)
   begin
      if (we3)
         regs[wa3] <= wd3;
   end

   assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
   assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

   noPcWrite: assert property (@(negedge clk) we3 |-> (wa3 != PC_REG));

endmodule

`default_nettype wire

//--- hdl/alu.sv
/*
 * ALU
 * Add, subtract, AND and ORR with NZCV flag generation
 */
`timescale 1ns/10ps
`default_nettype none

module alu import armPkg::*;
(
   input  word_t  a,
   input  word_t  b,
   input  aluOp_t aluControl,
   output word_t  result,
   output flags_t flags
);
   word_t               bInv;
   logic [DATA_WIDTH:0] sum;      // Carry out in the top bit
   logic                arith;

   assign arith = (aluControl == ALU_ADD) || (aluControl == ALU_SUB);
   assign bInv  = (aluControl == ALU_SUB) ? ~b : b;
   assign sum   = {1'b0, a} + {1'b0, bInv} + (aluControl == ALU_SUB);

   always_comb
   begin
      case (aluControl)
         ALU_AND: result = a & b;
         ALU_ORR: result = a | b;
         default: result = sum[DATA_WIDTH-1:0];
      endcase
   end

   assign flags.n = result[DATA_WIDTH-1];
   assign flags.z = (result == '0);
   assign flags.c = arith & sum[DATA_WIDTH];
   // Same-sign operands giving a result of the other sign
   assign flags.v = arith & (a[DATA_WIDTH-1] == bInv[DATA_WIDTH-1]) &
                    (a[DATA_WIDTH-1] != sum[DATA_WIDTH-1]);

endmodule

`default_nettype wire

//--- hdl/hazardIf.sv
/*
 * Hazard interface
 * Register addresses and write enables from the pipeline, forwarding
 * selects, stalls and flushes back from the hazard unit
 */
`timescale 1ns/10ps
`default_nettype none

interface hazardIf import armPkg::*;
(
   input logic clk,
   input logic reset
);
   regAddr_t ra1D;
   regAddr_t ra2D;
   regAddr_t ra1E;
   regAddr_t ra2E;
   regAddr_t wa3E;
   regAddr_t wa3M;
   regAddr_t wa3W;
   logic     regWriteM;
   logic     regWriteW;
   logic     memToRegE;
   logic     branchTakenE;
   fwdSel_t  forwardAE;
   fwdSel_t  forwardBE;
   logic     stallF;
   logic     stallD;
   logic     flushD;
   logic     flushE;

   modport datapath (
      output ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
      input  forwardAE, forwardBE, stallF, stallD, flushD, branchTakenE, regWriteW
   );

   modport control (
      output regWriteM, regWriteW, memToRegE, branchTakenE,
      input  flushE
   );

   modport hazard (
      input  clk, reset,
      input  ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
      input  regWriteM, regWriteW, memToRegE, branchTakenE,
      output forwardAE, forwardBE, stallF, stallD, flushD, flushE
   );

endinterface

`default_nettype wire

//--- hdl/armPkg.sv
/*
 * ARM core shared definitions
 * Word and register widths, instruction field enums, forwarding selects
 * and the NZCV flags type used across the pipeline
 */
`default_nettype none

package armPkg;

   localparam int DATA_WIDTH     = 32;
   localparam int REG_ADDR_WIDTH = 4;
   localparam int PC_REG         = 15;   // Reads as PC+8
   localparam int INSTR_BYTES    = 4;

   typedef logic [DATA_WIDTH-1:0]     word_t;
   typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   // Instruction bits 27:26
   typedef enum logic [1:0] {
      DATA_PROC = 2'b00,
      MEMORY    = 2'b01,
      BRANCH    = 2'b10
   } opClass_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_AND = 2'b10,
      ALU_ORR = 2'b11
   } aluOp_t;

   typedef enum logic [3:0] {
      EQ = 4'b0000,
      NE = 4'b0001,
      CS = 4'b0010,
      CC = 4'b0011,
      MI = 4'b0100,
      PL = 4'b0101,
      VS = 4'b0110,
      VC = 4'b0111,
      HI = 4'b1000,
      LS = 4'b1001,
      GE = 4'b1010,
      LT = 4'b1011,
      GT = 4'b1100,
      LE = 4'b1101,
      AL = 4'b1110
   } cond_t;

   typedef enum logic [1:0] {
      IMM8     = 2'b00,
      IMM12    = 2'b01,
      BRANCH24 = 2'b10
   } immSrc_t;

   typedef enum logic [1:0] {
      FWD_NONE      = 2'b00,
      FWD_WRITEBACK = 2'b01,
      FWD_MEMORY    = 2'b10
   } fwdSel_t;

endpackage

`default_nettype wire
